//--- Makefile
TOP = lc3Tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failures found" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
hw/lc3Pkg.sv
hw/datapathRegs.sv
hw/regFile.sv
hw/aluUnit.sv
hw/controlFsm.sv
hw/lc3Core.sv
tests/memModel.sv
tests/lc3Core_assert.sv
tests/lc3Tb.sv

//--- hw/aluUnit.sv
// ALU for ADD, AND, NOT and pass-through
// and the address adder with base and offset selects
`timescale 1ns/1ps
`default_nettype none

module aluUnit
(
	input  lc3Pkg::instrU    ir,
	input  lc3Pkg::wordT     sr1Data,
	input  lc3Pkg::wordT     sr2Data,
	input  lc3Pkg::wordT     pc,
	input  lc3Pkg::aluOpT    aluOp,
	input  lc3Pkg::addr1SelT addr1Sel,
	input  lc3Pkg::addr2SelT addr2Sel,
	output lc3Pkg::wordT     aluOut,
	output lc3Pkg::wordT     addrOut
);

	import lc3Pkg::*;

	wordT imm5Ext;
	wordT off9Ext;
	wordT bOperand;
	wordT addrBase;
	wordT addrOffset;

	assign imm5Ext = {{11{ir.operate.imm5[4]}}, ir.operate.imm5};
	assign off9Ext = {{7{ir.offset.pcOffset9[8]}}, ir.offset.pcOffset9};

	// Immediate or register second operand
	assign bOperand = ir.operate.immFlag ? imm5Ext : sr2Data;

	always_comb
	begin
		case (aluOp)
			aluAdd:   aluOut = sr1Data + bOperand;
			aluAnd:   aluOut = sr1Data & bOperand;
			aluNot:   aluOut = ~sr1Data;
			default:  aluOut = sr1Data;
		endcase
	end

	// Address adder
	assign addrBase = (addr1Sel == addr1Sr1) ? sr1Data : pc;

	always_comb
	begin
		case (addr2Sel)
			addr2Off9: addrOffset = off9Ext;
			default:   addrOffset = 16'h0000;
		endcase
	end

	assign addrOut = addrBase + addrOffset;

endmodule

`default_nettype wire

//--- hw/controlFsm.sv
// Multicycle fetch, decode and execute state machine
// with register index decoding and the branch condition
`timescale 1ns/1ps
`default_nettype none

module controlFsm
(
	input  logic               Clk,
	input  logic               arstN,
	input  lc3Pkg::instrU      ir,
	input  logic [2:0]         nzp,
	input  logic               memReady,
	output logic               loadMar,
	output logic               loadMdr,
	output logic               loadPc,
	output logic               loadIr,
	output lc3Pkg::pcSelT      pcSel,
	output lc3Pkg::busSelT     busSel,
	output lc3Pkg::aluOpT      aluOp,
	output lc3Pkg::addr1SelT   addr1Sel,
	output lc3Pkg::addr2SelT   addr2Sel,
	output logic               mdrFromMem,
	output logic               regWe,
	output logic               ldCc,
	output logic [2:0]         dr,
	output logic [2:0]         sr1,
	output logic [2:0]         sr2,
	output logic               memRead,
	output logic               memWrite
);

	import lc3Pkg::*;

	stateT state;
	stateT stateNext;
	logic  brTaken;

	// Register indices straight from the IR views
	assign dr  = ir.operate.dr;
	// ST reads its source from bits [11:9], JMP its base from the sr1 field
	assign sr1 = (ir.operate.opcode == opSt) ? ir.offset.drNzp : ir.operate.sr1;
	assign sr2 = ir.operate.imm5[2:0];

	assign brTaken = |(ir.offset.drNzp & nzp);

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= sReset;
		end
		else
		begin
			state <= stateNext;
		end
	end

	always_comb
	begin
		stateNext  = state;
		loadMar    = 1'b0;
		loadMdr    = 1'b0;
		loadPc     = 1'b0;
		loadIr     = 1'b0;
		pcSel      = pcInc;
		busSel     = busPc;
		aluOp      = aluPassA;
		addr1Sel   = addr1Pc;
		addr2Sel   = addr2Zero;
		mdrFromMem = 1'b0;
		regWe      = 1'b0;
		ldCc       = 1'b0;
		memRead    = 1'b0;
		memWrite   = 1'b0;

		case (state)
			sReset:
			begin
				stateNext = sFetchAddr;
			end
			// MAR <- PC, PC <- PC + 1
			sFetchAddr:
			begin
				busSel    = busPc;
				loadMar   = 1'b1;
				loadPc    = 1'b1;
				stateNext = sFetchWait;
			end
			sFetchWait:
			begin
				memRead    = 1'b1;
				mdrFromMem = 1'b1;
				loadMdr    = memReady;
				if (memReady)
				begin
					stateNext = sFetchIr;
				end
			end
			sFetchIr:
			begin
				busSel    = busMdr;
				loadIr    = 1'b1;
				stateNext = sDecode;
			end
			sDecode:
			begin
				case (ir.operate.opcode)
					opAdd, opAnd, opNot: stateNext = sOperate;
					opBr:                stateNext = sBranch;
					opJmp:               stateNext = sJump;
					opLd:                stateNext = sLdAddr;
					opSt:                stateNext = sStAddr;
					// Unsupported opcodes are skipped
					default:             stateNext = sFetchAddr;
				endcase
			end
			sOperate:
			begin
				case (ir.operate.opcode)
					opAnd:   aluOp = aluAnd;
					opNot:   aluOp = aluNot;
					default: aluOp = aluAdd;
				endcase
				busSel    = busAlu;
				regWe     = 1'b1;
				ldCc      = 1'b1;
				stateNext = sFetchAddr;
			end
			// PC already points past the branch
			sBranch:
			begin
				addr1Sel  = addr1Pc;
				addr2Sel  = addr2Off9;
				pcSel     = pcAddr;
				loadPc    = brTaken;
				stateNext = sFetchAddr;
			end
			sJump:
			begin
				addr1Sel  = addr1Sr1;
				addr2Sel  = addr2Zero;
				pcSel     = pcAddr;
				loadPc    = 1'b1;
				stateNext = sFetchAddr;
			end
			sLdAddr, sStAddr:
			begin
				addr1Sel  = addr1Pc;
				addr2Sel  = addr2Off9;
				busSel    = busAddr;
				loadMar   = 1'b1;
				stateNext = (state == sLdAddr) ? sLdWait : sStData;
			end
			sLdWait:
			begin
				memRead    = 1'b1;
				mdrFromMem = 1'b1;
				loadMdr    = memReady;
				if (memReady)
				begin
					stateNext = sLdWrite;
				end
			end
			sLdWrite:
			begin
				busSel    = busMdr;
				regWe     = 1'b1;
				ldCc      = 1'b1;
				stateNext = sFetchAddr;
			end
			// Store data goes through the ALU untouched
			sStData:
			begin
				aluOp     = aluPassA;
				busSel    = busAlu;
				loadMdr   = 1'b1;
				stateNext = sStWait;
			end
			sStWait:
			begin
				memWrite = 1'b1;
				if (memReady)
				begin
					stateNext = sFetchAddr;
				end
			end
			default:
			begin
				stateNext = sReset;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/datapathRegs.sv
// MAR, MDR, PC and IR registers
// with the PC source mux, MDR source mux and PC incrementer
`timescale 1ns/1ps
`default_nettype none

module datapathRegs
(
	input  logic          Clk,
	input  logic          arstN,
	input  lc3Pkg::wordT  bus,
	input  lc3Pkg::wordT  memRdData,
	input  lc3Pkg::wordT  addrOut,
	input  logic          loadMar,
	input  logic          loadMdr,
	input  logic          loadPc,
	input  logic          loadIr,
	input  lc3Pkg::pcSelT pcSel,
	input  logic          mdrFromMem,
	output lc3Pkg::wordT  mar,
	output lc3Pkg::wordT  mdr,
	output lc3Pkg::wordT  pc,
	output lc3Pkg::instrU ir
);

	import lc3Pkg::*;

	wordT pcPlusOne;
	wordT pcNext;
	wordT mdrNext;

	// PC incrementer
	assign pcPlusOne = pc + 16'd1;

	// PC source
	always_comb
	begin
		case (pcSel)
			pcAddr:
			begin
				pcNext = addrOut;
			end
			pcBus:
			begin
				pcNext = bus;
			end
			default:
			begin
				pcNext = pcPlusOne;
			end
		endcase
	end

	// MDR takes memory read data or the bus
	always_comb
	begin
		if (mdrFromMem)
		begin
			mdrNext = memRdData;
		end
		else
		begin
			mdrNext = bus;
		end
	end

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			mar <= '0;
			mdr <= '0;
			pc  <= resetPc;
			ir  <= '0;
		end
		else
		begin
			if (loadMar)
			begin
				mar <= bus;
			end
			if (loadMdr)
			begin
				mdr <= mdrNext;
			end
			if (loadPc)
			begin
				pc <= pcNext;
			end
			// IR is loaded from the bus, which carries the MDR during fetch
			if (loadIr)
			begin
				ir <= bus;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/lc3Core.sv
// LC-3 core top level
// Datapath, register file, ALU and control wired around the shared bus
`timescale 1ns/1ps
`default_nettype none

module lc3Core
(
	input  logic         Clk,
	input  logic         arstN,
	output lc3Pkg::wordT memAddr,
	output lc3Pkg::wordT memWrData,
	input  lc3Pkg::wordT memRdData,
	output logic         memRead,
	output logic         memWrite,
	input  logic         memReady
);

	import lc3Pkg::*;

	wordT     bus;
	wordT     mar;
	wordT     mdr;
	wordT     pc;
	instrU    ir;
	wordT     aluOut;
	wordT     addrOut;
	wordT     sr1Data;
	wordT     sr2Data;
	logic [2:0] nzp;
	logic [2:0] dr;
	logic [2:0] sr1;
	logic [2:0] sr2;
	logic     loadMar;
	logic     loadMdr;
	logic     loadPc;
	logic     loadIr;
	logic     mdrFromMem;
	logic     regWe;
	logic     ldCc;
	pcSelT    pcSel;
	busSelT   busSel;
	aluOpT    aluOp;
	addr1SelT addr1Sel;
	addr2SelT addr2Sel;

	// Shared bus driver
	always_comb
	begin
		case (busSel)
			busMdr:  bus = mdr;
			busAlu:  bus = aluOut;
			busAddr: bus = addrOut;
			default: bus = pc;
		endcase
	end

	assign memAddr   = mar;
	assign memWrData = mdr;

	datapathRegs datapathRegs_i (.Clk(Clk), .arstN(arstN), .bus(bus), .memRdData(memRdData),
		.addrOut(addrOut), .loadMar(loadMar), .loadMdr(loadMdr), .loadPc(loadPc),
		.loadIr(loadIr), .pcSel(pcSel), .mdrFromMem(mdrFromMem), .mar(mar), .mdr(mdr),
		.pc(pc), .ir(ir));

	regFile regFile_i (.Clk(Clk), .arstN(arstN), .we(regWe), .dr(dr), .sr1(sr1), .sr2(sr2),
		.wrData(bus), .ldCc(ldCc), .sr1Data(sr1Data), .sr2Data(sr2Data), .nzp(nzp));

	aluUnit aluUnit_i (.ir(ir), .sr1Data(sr1Data), .sr2Data(sr2Data), .pc(pc), .aluOp(aluOp),
		.addr1Sel(addr1Sel), .addr2Sel(addr2Sel), .aluOut(aluOut), .addrOut(addrOut));

	controlFsm controlFsm_i (.Clk(Clk), .arstN(arstN), .ir(ir), .nzp(nzp),
		.memReady(memReady), .loadMar(loadMar), .loadMdr(loadMdr), .loadPc(loadPc),
		.loadIr(loadIr), .pcSel(pcSel), .busSel(busSel), .aluOp(aluOp),
		.addr1Sel(addr1Sel), .addr2Sel(addr2Sel), .mdrFromMem(mdrFromMem), .regWe(regWe),
		.ldCc(ldCc), .dr(dr), .sr1(sr1), .sr2(sr2), .memRead(memRead), .memWrite(memWrite));

endmodule

`default_nettype wire

//--- hw/lc3Pkg.sv
// Shared LC-3 core definitions: word type, opcodes, instruction views,
// datapath mux selects, control states and the reset PC
`default_nettype none

package lc3Pkg;

	typedef logic [15:0] wordT;

	// PC after reset
	localparam wordT resetPc = 16'h3000;

	// Supported subset of the LC-3 opcode map
	typedef enum logic [3:0] {
		opBr  = 4'b0000,
		opAdd = 4'b0001,
		opLd  = 4'b0010,
		opSt  = 4'b0011,
		opAnd = 4'b0101,
		opNot = 4'b1001,
		opJmp = 4'b1100
	} opcodeT;

	// Operate format used by ADD, AND, NOT and JMP
	typedef struct packed
	{
		opcodeT     opcode;
		logic [2:0] dr;
		logic [2:0] sr1;
		logic       immFlag;
		// Holds sr2 in bits [2:0] when immFlag is clear
		logic [4:0] imm5;
	} operateT;

	// PC-relative format used by LD, ST and BR
	typedef struct packed
	{
		opcodeT     opcode;
		logic [2:0] drNzp;
		logic [8:0] pcOffset9;
	} offsetT;

	typedef union packed
	{
		operateT operate;
		offsetT  offset;
	} instrU;

	typedef enum logic [1:0] {
		pcInc  = 2'd0,
		pcAddr = 2'd1,
		pcBus  = 2'd2
	} pcSelT;

	typedef enum logic [1:0] {
		busPc   = 2'd0,
		busMdr  = 2'd1,
		busAlu  = 2'd2,
		busAddr = 2'd3
	} busSelT;

	typedef enum logic [1:0] {
		aluAdd   = 2'd0,
		aluAnd   = 2'd1,
		aluNot   = 2'd2,
		aluPassA = 2'd3
	} aluOpT;

	typedef enum logic [1:0] {
		addr2Zero = 2'd0,
		addr2Off9 = 2'd1
	} addr2SelT;

	typedef enum logic {
		addr1Pc  = 1'b0,
		addr1Sr1 = 1'b1
	} addr1SelT;

	typedef enum logic [3:0] {
		sReset,
		sFetchAddr,
		sFetchWait,
		sFetchIr,
		sDecode,
		sOperate,
		sBranch,
		sJump,
		sLdAddr,
		sLdWait,
		sLdWrite,
		sStAddr,
		sStData,
		sStWait
	} stateT;

endpackage

`default_nettype wire

//--- hw/regFile.sv
// Eight general registers, two asynchronous read ports
// and the NZP condition code register
`timescale 1ns/1ps
`default_nettype none

module regFile
(
	input  logic         Clk,
	input  logic         arstN,
	input  logic         we,
	input  logic [2:0]   dr,
	input  logic [2:0]   sr1,
	input  logic [2:0]   sr2,
	input  lc3Pkg::wordT wrData,
	input  logic         ldCc,
	output lc3Pkg::wordT sr1Data,
	output lc3Pkg::wordT sr2Data,
	output logic [2:0]   nzp
);

	import lc3Pkg::*;

	wordT regs [0:7];
	logic [2:0] ccNext;

	always_ff @(posedge Clk)
	begin
		if (we)
		begin
			regs[dr] <= wrData;
		end
	end

	assign sr1Data = regs[sr1];
	assign sr2Data = regs[sr2];

	// N in bit 2, Z in bit 1, P in bit 0
	assign ccNext = {wrData[15], wrData == 16'h0000, !wrData[15] && wrData != 16'h0000};

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			nzp <= 3'b010;
		end
		else if (ldCc)
		begin
			nzp <= ccNext;
		end
	end

endmodule

`default_nettype wire

//--- tests/lc3Core_assert.sv
// Concurrent checks on the core's memory request port
// and the bind into lc3Core
`timescale 1ns/1ps
`default_nettype none

module lc3Core_assert
(
	input logic Clk,
	input logic arstN,
	input logic memRead,
	input logic memWrite,
	input logic memReady
);

	// Number of failed assertions
	int failCount = 0;

	requestsExclusive: assert property (@(posedge Clk) disable iff (!arstN)
		!(memRead && memWrite))
	else
	begin
		failCount++;
		$error("memRead and memWrite are high in the same cycle");
	end

	// A request is held until memory answers
	readHeld: assert property (@(posedge Clk) disable iff (!arstN)
		memRead && !memReady |=> memRead)
	else
	begin
		failCount++;
		$error("memRead dropped before memReady");
	end

	writeHeld: assert property (@(posedge Clk) disable iff (!arstN)
		memWrite && !memReady |=> memWrite)
	else
	begin
		failCount++;
		$error("memWrite dropped before memReady");
	end

	idleInReset: assert property (@(posedge Clk) !arstN |-> !memRead && !memWrite)
	else
	begin
		failCount++;
		$error("Memory request raised during reset");
	end

endmodule

bind lc3Core lc3Core_assert coreAssert_i (.Clk(Clk), .arstN(arstN), .memRead(memRead),
	.memWrite(memWrite), .memReady(memReady));

`default_nettype wire

//--- tests/lc3Tb.sv
// LC-3 core testbench with clock, reset, instruction encoders,
// compare and wait tasks, directed tests for fetch, operate, LD/ST, BR and JMP
`timescale 1ns/1ps
`default_nettype none

module lc3Tb;

	import lc3Pkg::*;

	logic Clk;
	logic arstN;
	wordT memAddr;
	wordT memWrData;
	wordT memRdData;
	logic memRead;
	logic memWrite;
	logic memReady;

	lc3Core dut_i (.Clk(Clk), .arstN(arstN), .memAddr(memAddr), .memWrData(memWrData),
		.memRdData(memRdData), .memRead(memRead), .memWrite(memWrite), .memReady(memReady));

	memModel memory (.Clk(Clk), .arstN(arstN), .memAddr(memAddr), .memWrData(memWrData),
		.memRead(memRead), .memWrite(memWrite), .memRdData(memRdData), .memReady(memReady));

	initial
	begin
		Clk = 1'b0;
		forever #10 Clk = ~Clk;
	end

	// LC-3 instruction encodings
	function automatic wordT addRR(input logic [2:0] d, input logic [2:0] s1,
		input logic [2:0] s2);
		return {4'b0001, d, s1, 3'b000, s2};
	endfunction

	function automatic wordT addRI(input logic [2:0] d, input logic [2:0] s1, input int imm);
		return {4'b0001, d, s1, 1'b1, imm[4:0]};
	endfunction

	function automatic wordT andRR(input logic [2:0] d, input logic [2:0] s1,
		input logic [2:0] s2);
		return {4'b0101, d, s1, 3'b000, s2};
	endfunction

	function automatic wordT andRI(input logic [2:0] d, input logic [2:0] s1, input int imm);
		return {4'b0101, d, s1, 1'b1, imm[4:0]};
	endfunction

	function automatic wordT notR(input logic [2:0] d, input logic [2:0] s);
		return {4'b1001, d, s, 6'b111111};
	endfunction

	function automatic wordT ldPcRel(input logic [2:0] d, input int off);
		return {4'b0010, d, off[8:0]};
	endfunction

	function automatic wordT stPcRel(input logic [2:0] s, input int off);
		return {4'b0011, s, off[8:0]};
	endfunction

	function automatic wordT brPcRel(input logic [2:0] cond, input int off);
		return {4'b0000, cond, off[8:0]};
	endfunction

	function automatic wordT jmpReg(input logic [2:0] base);
		return {4'b1100, 3'b000, base, 6'b000000};
	endfunction

	// Target of a PC-relative field in the instruction at addr
	function automatic wordT pcRelative(input wordT addr, input int off);
		return addr + 16'd1 + {{7{off[8]}}, off[8:0]};
	endfunction

	task automatic stopWithFailure();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input wordT expected, input wordT actual);
		if (actual !== expected)
		begin
			$display("[FAIL] time %0t: %s expected %h, actual %h", $time, name, expected,
				actual);
			stopWithFailure();
		end
	endtask

	task automatic waitReads(input int count);
		int cycles;
		cycles = 0;
		while (memory.readLog.size() < count)
		begin
			@(posedge Clk);
			cycles++;
			if (cycles > 500)
			begin
				$display("Timed out after %0d cycles waiting for %0d memory reads", cycles,
					count);
				stopWithFailure();
			end
		end
	endtask

	task automatic waitWrites(input int count);
		int cycles;
		cycles = 0;
		while (memory.writeAddrLog.size() < count)
		begin
			@(posedge Clk);
			cycles++;
			if (cycles > 500)
			begin
				$display("Timed out after %0d cycles waiting for %0d memory writes", cycles,
					count);
				stopWithFailure();
			end
		end
	endtask

	// Hold the core in reset while a new program is loaded
	task automatic enterReset(input logic randomWaits, input int fixedWait);
		@(negedge Clk);
		arstN = 1'b0;
		memory.fillImage();
		memory.setWaits(randomWaits, fixedWait);
	endtask

	task automatic releaseReset();
		repeat (8) @(negedge Clk);
		arstN = 1'b1;
	endtask

	// Straight-line code is fetched from resetPc upward
	task automatic fetchOrderTest(input logic randomWaits, input int fixedWait);
		enterReset(randomWaits, fixedWait);
		for (int i = 0; i < 8; i++)
		begin
			memory.writeWord(16'h3000 + i[15:0], andRI(3'd0, 3'd0, 0));
		end
		memory.writeWord(16'h3008, brPcRel(3'b111, -1));
		releaseReset();
		waitReads(8);
		for (int i = 0; i < 8; i++)
		begin
			checkWord("fetch memAddr", 16'h3000 + i[15:0], memory.readLog[i]);
		end
	endtask

	task automatic operateTest(input logic randomWaits, input int fixedWait);
		wordT r1;
		wordT r2;
		wordT expData [$];
		r1 = 16'd13;
		r2 = 16'd0 - 16'd7;
		expData = '{r1 + r2, r1 + (16'd0 - 16'd16), r1 & r2, r2 & 16'd10, ~r1};
		enterReset(randomWaits, fixedWait);
		memory.writeWord(16'h3000, andRI(3'd1, 3'd1, 0));
		memory.writeWord(16'h3001, addRI(3'd1, 3'd1, 13));
		memory.writeWord(16'h3002, andRI(3'd2, 3'd2, 0));
		memory.writeWord(16'h3003, addRI(3'd2, 3'd2, -7));
		memory.writeWord(16'h3004, addRR(3'd3, 3'd1, 3'd2));
		memory.writeWord(16'h3005, addRI(3'd4, 3'd1, -16));
		memory.writeWord(16'h3006, andRR(3'd5, 3'd1, 3'd2));
		memory.writeWord(16'h3007, andRI(3'd6, 3'd2, 10));
		memory.writeWord(16'h3008, notR(3'd7, 3'd1));
		// Store R3 to R7 in order
		for (int i = 0; i < 5; i++)
		begin
			memory.writeWord(16'h3009 + i[15:0], stPcRel(3'd3 + i[2:0], 32));
		end
		memory.writeWord(16'h300E, brPcRel(3'b111, -1));
		releaseReset();
		waitWrites(5);
		for (int i = 0; i < 5; i++)
		begin
			checkWord("memAddr", pcRelative(16'h3009 + i[15:0], 32), memory.writeAddrLog[i]);
			checkWord("memWrData", expData[i], memory.writeDataLog[i]);
		end
	endtask

	task automatic loadStoreTest(input logic randomWaits, input int fixedWait);
		enterReset(randomWaits, fixedWait);
		memory.writeWord(16'h3000, ldPcRel(3'd2, -17));
		memory.writeWord(16'h3001, stPcRel(3'd2, 32));
		memory.writeWord(16'h3002, brPcRel(3'b111, -1));
		memory.writeWord(pcRelative(16'h3000, -17), 16'hC3A5);
		releaseReset();
		waitWrites(1);
		checkWord("load memAddr", pcRelative(16'h3000, -17), memory.readLog[1]);
		checkWord("memAddr", pcRelative(16'h3001, 32), memory.writeAddrLog[0]);
		checkWord("memWrData", 16'hC3A5, memory.writeDataLog[0]);
	endtask

	// Branches after zero, negative and positive results
	task automatic branchTest(input logic randomWaits, input int fixedWait);
		wordT expFetch [$];
		expFetch = '{16'h3000, 16'h3001, pcRelative(16'h3001, 2), 16'h3005, 16'h3006,
			pcRelative(16'h3006, 2), 16'h300A, 16'h300B, pcRelative(16'h300B, 4),
			pcRelative(16'h3010, -1)};
		enterReset(randomWaits, fixedWait);
		memory.writeWord(16'h3000, andRI(3'd1, 3'd1, 0));
		memory.writeWord(16'h3001, brPcRel(3'b010, 2));
		memory.writeWord(16'h3004, addRI(3'd1, 3'd1, -1));
		memory.writeWord(16'h3005, brPcRel(3'b001, 3));
		memory.writeWord(16'h3006, brPcRel(3'b100, 2));
		memory.writeWord(16'h3009, addRI(3'd1, 3'd1, 2));
		memory.writeWord(16'h300A, brPcRel(3'b110, 3));
		memory.writeWord(16'h300B, brPcRel(3'b001, 4));
		memory.writeWord(16'h3010, brPcRel(3'b111, -1));
		releaseReset();
		waitReads(10);
		for (int i = 0; i < 10; i++)
		begin
			checkWord("fetch memAddr", expFetch[i], memory.readLog[i]);
		end
	endtask

	task automatic jumpTest(input logic randomWaits, input int fixedWait);
		enterReset(randomWaits, fixedWait);
		memory.writeWord(16'h3000, ldPcRel(3'd3, 2));
		memory.writeWord(16'h3001, jmpReg(3'd3));
		memory.writeWord(16'h3003, 16'h3040);
		memory.writeWord(16'h3040, brPcRel(3'b111, -1));
		releaseReset();
		waitReads(4);
		checkWord("load memAddr", pcRelative(16'h3000, 2), memory.readLog[1]);
		checkWord("jump fetch memAddr", 16'h3040, memory.readLog[3]);
	endtask

	initial
	begin
		arstN = 1'b0;
		void'($urandom(32'h561f));

		fetchOrderTest(1'b0, 0);
		fetchOrderTest(1'b0, 3);
		fetchOrderTest(1'b1, 0);

		operateTest(1'b0, 1);
		loadStoreTest(1'b0, 1);
		branchTest(1'b0, 1);
		jumpTest(1'b0, 1);

		// Same programs with random wait states
		operateTest(1'b1, 0);
		loadStoreTest(1'b1, 0);
		branchTest(1'b1, 0);
		jumpTest(1'b1, 0);

		if (dut_i.coreAssert_i.failCount == 0)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
		begin
			$display("%0d assertion failures on the memory port", dut_i.coreAssert_i.failCount);
			stopWithFailure();
		end
	end

endmodule

`default_nettype wire

//--- tests/memModel.sv
// Behavioural memory for the core's strobe and ready port
// Wait states per access, write overlay, read and write logs
`timescale 1ns/1ps
`default_nettype none

module memModel
(
	input  logic         Clk,
	input  logic         arstN,
	input  lc3Pkg::wordT memAddr,
	input  lc3Pkg::wordT memWrData,
	input  logic         memRead,
	input  logic         memWrite,
	output lc3Pkg::wordT memRdData,
	output logic         memReady
);

	import lc3Pkg::*;

	// Program image, loaded by the testbench
	wordT mem [0:65535];
	// Words stored by the core since the last reset
	wordT written [wordT];
	int   waitTable [0:255];

	wordT readLog [$];
	wordT writeAddrLog [$];
	wordT writeDataLog [$];

	logic readyReg = 1'b0;
	wordT rdDataReg = '0;
	logic busy = 1'b0;
	int   waitLeft = 0;
	int   accessCount = 0;

	assign memReady  = readyReg;
	assign memRdData = rdDataReg;

	// Every word gets a pattern of its own address
	task automatic fillImage();
		for (int a = 0; a < 65536; a++)
		begin
			mem[a[15:0]] = a[15:0] ^ 16'h5A5A;
		end
	endtask

	task automatic writeWord(input wordT addr, input wordT data);
		mem[addr] = data;
	endtask

	// Wait cycles of each access, random 0 to 3 or a fixed count
	task automatic setWaits(input logic randomWaits, input int fixedWait);
		for (int i = 0; i < 256; i++)
		begin
			waitTable[i[7:0]] = randomWaits ? int'($urandom_range(3, 0)) : fixedWait;
		end
	endtask

	always @(negedge Clk)
	begin
		if (!arstN)
		begin
			readyReg    = 1'b0;
			busy        = 1'b0;
			accessCount = 0;
			readLog.delete();
			writeAddrLog.delete();
			writeDataLog.delete();
			written.delete();
		end
		else if (readyReg)
		begin
			// Ready is a single cycle pulse
			readyReg = 1'b0;
			busy     = 1'b0;
		end
		else if (memRead || memWrite)
		begin
			if (!busy)
			begin
				busy     = 1'b1;
				waitLeft = waitTable[accessCount[7:0]];
				accessCount++;
				if (memRead)
				begin
					readLog.push_back(memAddr);
				end
			end
			if (waitLeft > 0)
			begin
				waitLeft--;
			end
			else
			begin
				readyReg = 1'b1;
				if (memRead)
				begin
					rdDataReg = written.exists(memAddr) ? written[memAddr] : mem[memAddr];
				end
				else
				begin
					written[memAddr] = memWrData;
					writeAddrLog.push_back(memAddr);
					writeDataLog.push_back(memWrData);
				end
			end
		end
	end

endmodule

`default_nettype wire
